//--- design/msx_audio_pkg.sv
package msx_audio_pkg;

	// Mixed and scaled sample, two's complement
	typedef logic signed [15:0] sample_t;

	// Offset binary, 16'h8000 is silence
	typedef logic [15:0] dac_word_t;

	// 7 is full scale, each step down halves the level
	typedef logic [2:0] volume_t;

	typedef logic [15:0] opl3_t;          // OPL3 output is unsigned
	typedef logic signed [14:0] scc_t;

	typedef struct packed {
		sample_t          opll;
		opl3_t            opl3_l;
		opl3_t            opl3_r;
		scc_t             scc1_l;
		scc_t             scc1_r;
		scc_t             scc2_l;
		scc_t             scc2_r;
		logic [8:0]       psg;            // Unsigned
		logic signed [7:0] pcm;
	} audio_src_t;

	typedef struct packed {
		dac_word_t left;
		dac_word_t right;
	} stereo_dac_t;

	localparam dac_word_t DAC_MID = 16'h8000;

endpackage

//--- design/msx_io_pkg.sv
package msx_io_pkg;

	// Port lines as the MSX sees them, 1 is released
	typedef logic [5:0] joy_lines_t;

	typedef logic [8:0] mouse_axis_t;

	typedef struct packed {
		mouse_axis_t x;
		mouse_axis_t y;
		logic [1:0]  buttons;
	} mouse_report_t;

	typedef logic [15:0] status_t;
	typedef logic [7:0] dip_t;

	// Nibble order of the MSX mouse protocol
	typedef enum logic [1:0] {
		X_HIGH,
		X_LOW,
		Y_HIGH,
		Y_LOW
	} mouse_state_t;

	// Menu status bits
	localparam int STATUS_RESET_BIT = 0;
	localparam int STATUS_CPU_CLK_BIT = 1;
	localparam int STATUS_OPT_LO = 3;
	localparam int STATUS_OPT_HI = 8;
	localparam int STATUS_TAPE_BIT = 9;

endpackage

//--- design/board_control.sv
module board_control #(
	parameter int IMG_RESET_CYCLES = 2 ** 25
) (
	input  logic                clk_sys,
	input  logic                reset_i,
	input  logic                pll_locked_i,
	input  logic                button_reset_i,
	input  msx_io_pkg::status_t status_i,
	input  logic                img_mounted_i,
	output logic                sys_reset_o,
	output msx_io_pkg::dip_t    dip_o
);
	import msx_io_pkg::*;

	localparam int CNT_W = $clog2(IMG_RESET_CYCLES + 1);

	logic [CNT_W-1:0] img_cnt;
	logic             reset_req;

	// The mount pulse itself counts, so reset lasts one cycle longer than the countdown
	assign reset_req = reset_i
		| status_i[STATUS_RESET_BIT]
		| button_reset_i
		| ~pll_locked_i
		| img_mounted_i
		| (img_cnt != '0);

	always_ff @(posedge clk_sys) begin
		if (reset_i)
			img_cnt <= '0;
		else if (img_mounted_i)
			img_cnt <= CNT_W'(IMG_RESET_CYCLES);    // Restart on every new image
		else if (img_cnt != '0)
			img_cnt <= img_cnt - 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		sys_reset_o <= reset_req;
	end

	// Switches are active low on the MSX side
	always_ff @(posedge clk_sys) begin
		dip_o <= {
			~status_i[STATUS_OPT_HI:STATUS_OPT_LO],
			1'b0,
			~status_i[STATUS_CPU_CLK_BIT]
		};
	end

endmodule

//--- design/mouse_port.sv
module mouse_port #(
	parameter int MOUSE_TIMEOUT_CYCLES = 100000
) (
	input  logic                      clk_sys,
	input  logic                      reset_i,
	input  logic                      mouse_strobe_i,
	input  msx_io_pkg::mouse_report_t mouse_i,
	input  msx_io_pkg::joy_lines_t    joy_a_i,
	input  msx_io_pkg::joy_lines_t    joy_b_i,
	input  logic                      stra_i,
	input  logic                      strb_i,
	output msx_io_pkg::joy_lines_t    port_a_o,
	output msx_io_pkg::joy_lines_t    port_b_o
);
	import msx_io_pkg::*;

	localparam int TMO_W = $clog2(MOUSE_TIMEOUT_CYCLES + 1);

	mouse_state_t     state;
	logic             mouse_en;
	mouse_axis_t      x_latch;
	mouse_axis_t      y_latch;
	logic [1:0]       btn_latch;
	logic [3:0]       nibble;
	logic [TMO_W-1:0] timeout;
	logic             stra_q;
	logic             stra_qq;
	logic             stra_toggle;

	// Line 0 gets the highest bit of the nibble
	function automatic logic [3:0] line_order(input logic [3:0] bits);
		return {bits[0], bits[1], bits[2], bits[3]};
	endfunction

	// Pressed line pulls low only while the port strobe is low
	function automatic joy_lines_t strobe_gate(input joy_lines_t pressed, input logic strobe);
		return ~(pressed & {$bits(joy_lines_t){~strobe}});
	endfunction

	assign stra_toggle = stra_q ^ stra_qq;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			stra_q <= 1'b0;
			stra_qq <= 1'b0;
		end else begin
			stra_q <= stra_i;
			stra_qq <= stra_q;
		end
	end

	// Joystick activity hands the port back
	always_ff @(posedge clk_sys) begin
		if (reset_i)
			mouse_en <= 1'b0;
		else if (mouse_strobe_i)
			mouse_en <= 1'b1;
		else if (|joy_a_i)
			mouse_en <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			state <= X_HIGH;
			x_latch <= '0;
			y_latch <= '0;
			btn_latch <= '0;
			nibble <= '0;
			timeout <= '0;
		end else begin
			if (mouse_en) begin
				if (timeout != '0) begin
					timeout <= timeout - 1'b1;
					if (timeout == TMO_W'(1))
						state <= X_HIGH;    // Host gave up mid report
				end
				if (stra_toggle) begin
					timeout <= TMO_W'(MOUSE_TIMEOUT_CYCLES);
					case (state)
						X_HIGH: begin
							nibble <= line_order(x_latch[8:5]);
							state <= X_LOW;
						end
						X_LOW: begin
							nibble <= line_order(x_latch[4:1]);
							state <= Y_HIGH;
						end
						Y_HIGH: begin
							nibble <= line_order(y_latch[8:5]);
							state <= Y_LOW;
						end
						Y_LOW: begin
							nibble <= line_order(y_latch[4:1]);
							state <= X_HIGH;
							x_latch <= '0;    // Motion consumed
							y_latch <= '0;
						end
					endcase
				end
			end
			if (mouse_strobe_i) begin
				x_latch <= '0 - mouse_i.x;    // MSX counts x the other way
				y_latch <= mouse_i.y;
				btn_latch <= mouse_i.buttons;
			end
		end
	end

	assign port_a_o = mouse_en ? {~btn_latch, nibble} : strobe_gate(joy_a_i, stra_i);
	assign port_b_o = strobe_gate(joy_b_i, strb_i);

endmodule

//--- design/audio_mixer.sv
module audio_mixer (
	input  logic                       clk_sys,
	input  logic                       reset_i,
	input  msx_audio_pkg::audio_src_t  audio_src_i,
	input  logic                       ear_i,
	input  logic                       tape_en_i,
	input  msx_audio_pkg::volume_t     volume_i,
	output msx_audio_pkg::stereo_dac_t dac_o
);
	import msx_audio_pkg::*;

	sample_t    shared;
	sample_t    sum_l;
	sample_t    sum_r;
	sample_t    scaled_l;
	sample_t    scaled_r;
	logic [2:0] shift;

	// One side of the mix, all terms wrap at 16 bits
	function automatic sample_t side_sum(
		input sample_t base,
		input opl3_t   opl3,
		input scc_t    scc1,
		input scc_t    scc2
	);
		sample_t scc;
		scc = sample_t'({scc1[14], scc1}) + sample_t'({scc2[14], scc2});
		return base + sample_t'(opl3) + scc;
	endfunction

	// Sources common to both channels
	assign shared = audio_src_i.opll
		+ sample_t'({1'b0, audio_src_i.psg, 6'b0})
		+ sample_t'({audio_src_i.pcm, audio_src_i.pcm})
		+ sample_t'({8'b0, ear_i & tape_en_i, 7'b0});

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= side_sum(shared, audio_src_i.opl3_l, audio_src_i.scc1_l,
				audio_src_i.scc2_l);
			sum_r <= side_sum(shared, audio_src_i.opl3_r, audio_src_i.scc1_r,
				audio_src_i.scc2_r);
		end
	end

	assign shift = 3'd7 - volume_i;
	assign scaled_l = sum_l >>> shift;
	assign scaled_r = sum_r >>> shift;

	// Flip sign bit for offset binary
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			dac_o.left <= DAC_MID;
			dac_o.right <= DAC_MID;
		end else begin
			dac_o.left <= {~scaled_l[15], scaled_l[14:0]};
			dac_o.right <= {~scaled_r[15], scaled_r[14:0]};
		end
	end

endmodule

//--- design/sigma_delta_dac.sv
module sigma_delta_dac #(
	parameter int DAC_BITS = 16
) (
	input  logic                     clk_sys,
	input  logic                     reset_i,
	input  msx_audio_pkg::dac_word_t dac_i,
	output logic                     dac_o
);
	import msx_audio_pkg::*;

	localparam int WORD_W = $bits(dac_word_t);

	logic [DAC_BITS-1:0] acc;
	logic [DAC_BITS:0]   acc_next;

	// Only the top DAC_BITS of the word reach the modulator
	assign acc_next = {1'b0, acc} + {1'b0, dac_i[WORD_W-1 -: DAC_BITS]};

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			acc <= '0;
			dac_o <= 1'b0;
		end else begin
			acc <= acc_next[DAC_BITS-1:0];
			dac_o <= acc_next[DAC_BITS];    // Carry is the pulse
		end
	end

endmodule

//--- design/msx_board_io.sv
module msx_board_io #(
	parameter int IMG_RESET_CYCLES = 2 ** 25,
	parameter int MOUSE_TIMEOUT_CYCLES = 100000,
	parameter int DAC_BITS = 16
) (
	input  logic                      clk_sys,
	input  logic                      reset_i,
	input  logic                      pll_locked_i,
	input  logic                      button_reset_i,
	input  msx_io_pkg::status_t       status_i,
	input  logic                      img_mounted_i,
	input  logic                      mouse_strobe_i,
	input  msx_io_pkg::mouse_report_t mouse_i,
	input  msx_io_pkg::joy_lines_t    joy_a_i,
	input  msx_io_pkg::joy_lines_t    joy_b_i,
	input  logic                      stra_i,
	input  logic                      strb_i,
	input  msx_audio_pkg::audio_src_t audio_src_i,
	input  msx_audio_pkg::volume_t    volume_i,
	input  logic                      ear_i,
	output logic                      sys_reset_o,
	output msx_io_pkg::dip_t          dip_o,
	output msx_io_pkg::joy_lines_t    port_a_o,
	output msx_io_pkg::joy_lines_t    port_b_o,
	output logic                      audio_l_o,
	output logic                      audio_r_o
);
	import msx_io_pkg::*;
	import msx_audio_pkg::*;

	stereo_dac_t dac_word;

	board_control #(
		.IMG_RESET_CYCLES(IMG_RESET_CYCLES)
	) board_control_i (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.pll_locked_i  (pll_locked_i),
		.button_reset_i(button_reset_i),
		.status_i      (status_i),
		.img_mounted_i (img_mounted_i),
		.sys_reset_o   (sys_reset_o),
		.dip_o         (dip_o)
	);

	// Ports and audio run from the combined system reset
	mouse_port #(
		.MOUSE_TIMEOUT_CYCLES(MOUSE_TIMEOUT_CYCLES)
	) mouse_port_i (
		.clk_sys       (clk_sys),
		.reset_i       (sys_reset_o),
		.mouse_strobe_i(mouse_strobe_i),
		.mouse_i       (mouse_i),
		.joy_a_i       (joy_a_i),
		.joy_b_i       (joy_b_i),
		.stra_i        (stra_i),
		.strb_i        (strb_i),
		.port_a_o      (port_a_o),
		.port_b_o      (port_b_o)
	);

	audio_mixer audio_mixer_i (
		.clk_sys    (clk_sys),
		.reset_i    (sys_reset_o),
		.audio_src_i(audio_src_i),
		.ear_i      (ear_i),
		.tape_en_i  (status_i[STATUS_TAPE_BIT]),
		.volume_i   (volume_i),
		.dac_o      (dac_word)
	);

	sigma_delta_dac #(
		.DAC_BITS(DAC_BITS)
	) dac_left (
		.clk_sys(clk_sys),
		.reset_i(sys_reset_o),
		.dac_i  (dac_word.left),
		.dac_o  (audio_l_o)
	);

	sigma_delta_dac #(
		.DAC_BITS(DAC_BITS)
	) dac_right (
		.clk_sys(clk_sys),
		.reset_i(sys_reset_o),
		.dac_i  (dac_word.right),
		.dac_o  (audio_r_o)
	);

endmodule

//--- tests/tb_msx_board_io.sv
module tb_msx_board_io;
	timeunit 1ns;
	timeprecision 100ps;

	import msx_io_pkg::*;
	import msx_audio_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam logic [31:0] SEED = 32'hf896_ba40;
	localparam int IMG_CYCLES = 40;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int DAC_BITS = 10;
	localparam int WINDOW = 1 << DAC_BITS;    // Ones count is exact over this many cycles
	localparam int SETTLE = 1100;
	localparam int AUDIO_SETS = 4;
	localparam int TOGGLE_GAP = 10;
	localparam int IDLE_CYCLES = 250;
	localparam int TAPE_BIT = 9;

	// Cycle budget per test for the watchdog
	localparam int TOTAL_CYCLES = 120 + 80 + 600 + 40 + AUDIO_SETS * (SETTLE + WINDOW + 20);

	logic          clk_sys = 1'b0;
	logic          reset_i;
	logic          pll_locked_i;
	logic          button_reset_i;
	status_t       status_i;
	logic          img_mounted_i;
	logic          mouse_strobe_i;
	mouse_report_t mouse_i;
	joy_lines_t    joy_a_i;
	joy_lines_t    joy_b_i;
	logic          stra_i;
	logic          strb_i;
	audio_src_t    audio_src_i;
	volume_t       volume_i;
	logic          ear_i;
	logic          sys_reset_o;
	dip_t          dip_o;
	joy_lines_t    port_a_o;
	joy_lines_t    port_b_o;
	logic          audio_l_o;
	logic          audio_r_o;

	// Pending comparisons for the checker
	string chk_name_q[$];
	int    chk_exp_q[$];
	int    chk_act_q[$];
	int    chk_tol_q[$];
	event  check_ev;

	int    errors = 0;
	int    checks = 0;
	int    tests_run = 0;
	int    tests_bad = 0;
	int    test_err_start;
	int    test_chk_start;
	string test_name;

	msx_board_io #(
		.IMG_RESET_CYCLES(IMG_CYCLES),
		.MOUSE_TIMEOUT_CYCLES(TIMEOUT_CYCLES),
		.DAC_BITS(DAC_BITS)
	) msx_board_io_i (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.pll_locked_i  (pll_locked_i),
		.button_reset_i(button_reset_i),
		.status_i      (status_i),
		.img_mounted_i (img_mounted_i),
		.mouse_strobe_i(mouse_strobe_i),
		.mouse_i       (mouse_i),
		.joy_a_i       (joy_a_i),
		.joy_b_i       (joy_b_i),
		.stra_i        (stra_i),
		.strb_i        (strb_i),
		.audio_src_i   (audio_src_i),
		.volume_i      (volume_i),
		.ear_i         (ear_i),
		.sys_reset_o   (sys_reset_o),
		.dip_o         (dip_o),
		.port_a_o      (port_a_o),
		.port_b_o      (port_b_o),
		.audio_l_o     (audio_l_o),
		.audio_r_o     (audio_r_o)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic reset_level(input logic rst, input status_t st, input logic button,
		input logic locked);
		return rst | st[0] | button | ~locked;
	endfunction

	function automatic dip_t dip_word(input status_t st);
		dip_t d;
		int   i;
		d[0] = ~st[1];
		d[1] = 1'b0;
		for (i = 0; i < 6; i++)
			d[2 + i] = ~st[3 + i];
		return d;
	endfunction

	// Index 0 to 3 walks the four nibbles in order
	function automatic joy_lines_t mouse_nibble_lines(input mouse_report_t rep, input int idx);
		logic [8:0] x_neg;
		logic [8:0] axis;
		logic [3:0] bits;
		joy_lines_t lines;
		x_neg = ~rep.x + 9'd1;
		axis = (idx % 4 < 2) ? x_neg : rep.y;
		bits = (idx % 2 == 0) ? axis[8:5] : axis[4:1];
		if (idx >= 4)
			bits = '0;    // Latches already cleared
		lines[0] = bits[3];    // MSB first on line 0
		lines[1] = bits[2];
		lines[2] = bits[1];
		lines[3] = bits[0];
		lines[4] = ~rep.buttons[0];
		lines[5] = ~rep.buttons[1];
		return lines;
	endfunction

	function automatic joy_lines_t joy_lines(input joy_lines_t pressed, input logic strobe);
		joy_lines_t lines;
		int         i;
		for (i = 0; i < 6; i++)
			lines[i] = (pressed[i] && !strobe) ? 1'b0 : 1'b1;
		return lines;
	endfunction

	function automatic int mixed_dac_word(input audio_src_t src, input volume_t vol,
		input logic tape, input logic ear, input logic right_side);
		int          sum;
		logic [15:0] wrapped;
		int          scaled;
		sum = int'($signed(src.opll)) + int'(src.psg) * 64 + int'($unsigned(src.pcm)) * 257;
		if (right_side)
			sum = sum + int'(src.opl3_r) + int'($signed(src.scc1_r)) + int'($signed(src.scc2_r));
		else
			sum = sum + int'(src.opl3_l) + int'($signed(src.scc1_l)) + int'($signed(src.scc2_l));
		if (tape && ear)
			sum = sum + 128;
		wrapped = sum[15:0];
		scaled = int'($signed(wrapped)) >>> (7 - int'(vol));
		return scaled + 32768;    // Offset binary
	endfunction

	function automatic audio_src_t random_sources();
		audio_src_t  s;
		logic [31:0] r;
		r = $urandom;
		s.opll = r[15:0];
		s.opl3_l = r[31:16];
		r = $urandom;
		s.opl3_r = r[15:0];
		s.scc1_l = r[30:16];
		r = $urandom;
		s.scc1_r = r[14:0];
		s.scc2_l = r[29:15];
		r = $urandom;
		s.scc2_r = r[14:0];
		s.psg = r[23:15];
		s.pcm = r[31:24];
		return s;
	endfunction

	function automatic mouse_report_t pick_report();
		mouse_report_t rep;
		logic [31:0]   r;
		r = $urandom;
		rep.x = r[8:0];
		rep.y = r[17:9];
		rep.buttons = r[19:18];
		return rep;
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic post_check(input string name, input int exp_v, input int act_v, input int tol);
		chk_name_q.push_back(name);
		chk_exp_q.push_back(exp_v);
		chk_act_q.push_back(act_v);
		chk_tol_q.push_back(tol);
		-> check_ev;
	endtask

	initial begin
		string name;
		int    exp_v;
		int    act_v;
		int    tol;
		forever begin
			@(check_ev);
			while (chk_name_q.size() != 0) begin
				name = chk_name_q.pop_front();
				exp_v = chk_exp_q.pop_front();
				act_v = chk_act_q.pop_front();
				tol = chk_tol_q.pop_front();
				checks++;
				if (tol == 0) begin
					assert (act_v == exp_v) else begin
						$display("error %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
						errors++;
					end
				end else begin
					assert (act_v >= exp_v - tol && act_v <= exp_v + tol) else begin
						$display("error %s expected 0x%0h within %0d actual 0x%0h",
							name, exp_v, tol, act_v);
						errors++;
					end
				end
			end
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_err_start = errors;
		test_chk_start = checks;
	endtask

	task automatic finish_test();
		#1;    // Let the checker drain
		tests_run++;
		if (errors == test_err_start) begin
			$display("%s: ok, %0d checks", test_name, checks - test_chk_start);
		end else begin
			$display("%s: FAILED, %0d errors", test_name, errors - test_err_start);
			tests_bad++;
		end
	endtask

	task automatic reset_case(input status_t st, input logic button, input logic locked);
		next_cycle();
		status_i = st;
		button_reset_i = button;
		pll_locked_i = locked;
		next_cycle();
		@(negedge clk_sys);
		post_check("sys_reset_o", int'(reset_level(1'b0, st, button, locked)),
			int'(sys_reset_o), 0);
	endtask

	task automatic reset_dip_test();
		int          high_cycles;
		int          n;
		logic [31:0] rnd;
		status_t     st;
		start_test("reset and dip switches");
		@(negedge clk_sys);
		post_check("sys_reset_o", int'(reset_level(reset_i, status_i, 1'b0, 1'b1)),
			int'(sys_reset_o), 0);
		next_cycle();
		next_cycle();
		reset_i = 1'b0;    // Held for 3 cycles
		next_cycle();
		@(negedge clk_sys);
		post_check("sys_reset_o", int'(reset_level(reset_i, status_i, 1'b0, 1'b1)),
			int'(sys_reset_o), 0);
		reset_case(16'h0001, 1'b0, 1'b1);
		reset_case(16'h0000, 1'b0, 1'b1);
		reset_case(16'h0000, 1'b1, 1'b1);
		repeat (4) reset_case(16'h0000, 1'b0, 1'b0);
		reset_case(16'h0000, 1'b0, 1'b1);
		next_cycle();
		img_mounted_i = 1'b1;
		next_cycle();
		img_mounted_i = 1'b0;
		high_cycles = 0;
		while (high_cycles < 4 * IMG_CYCLES) begin
			@(negedge clk_sys);
			if (!sys_reset_o)
				break;
			high_cycles++;
		end
		post_check("sys_reset_o high cycles", IMG_CYCLES + 1, high_cycles, 0);
		for (n = 0; n < 8; n++) begin
			next_cycle();
			rnd = $urandom;
			st = rnd[15:0];
			st[0] = 1'b0;    // Keep the system out of reset
			status_i = st;
			next_cycle();
			@(negedge clk_sys);
			post_check("dip_o", int'(dip_word(st)), int'(dip_o), 0);
		end
		next_cycle();
		status_i = '0;
		finish_test();
	endtask

	// Enters at a drive point and leaves TOGGLE_GAP cycles later
	task automatic toggle_and_check(input joy_lines_t exp_lines);
		stra_i = ~stra_i;
		repeat (3) next_cycle();
		@(negedge clk_sys);
		post_check("port_a_o", int'(exp_lines), int'(port_a_o), 0);
		repeat (TOGGLE_GAP - 3) next_cycle();
	endtask

	task automatic send_report(input mouse_report_t rep);
		next_cycle();
		mouse_i = rep;
		mouse_strobe_i = 1'b1;
		next_cycle();
		mouse_strobe_i = 1'b0;
	endtask

	task automatic mouse_test();
		mouse_report_t rep;
		int            n;
		start_test("mouse nibble sequence");
		rep = pick_report();
		send_report(rep);
		for (n = 0; n < 5; n++)
			toggle_and_check(mouse_nibble_lines(rep, n));
		finish_test();
	endtask

	task automatic timeout_fallback_test();
		mouse_report_t rep;
		logic [31:0]   rnd;
		joy_lines_t    joy;
		start_test("mouse timeout and joystick fallback");
		repeat (IDLE_CYCLES) next_cycle();    // Sequencer back at x high
		rep = pick_report();
		if (mouse_nibble_lines(rep, 2) == mouse_nibble_lines(rep, 0))
			rep.y[8] = ~rep.y[8];    // Y high nibble must differ from x high
		send_report(rep);
		toggle_and_check(mouse_nibble_lines(rep, 0));
		toggle_and_check(mouse_nibble_lines(rep, 1));
		repeat (IDLE_CYCLES) next_cycle();
		toggle_and_check(mouse_nibble_lines(rep, 0));
		rnd = $urandom;
		joy = rnd[5:0];
		if (joy == '0)
			joy = 6'h01;
		joy_a_i = joy;
		stra_i = rnd[8];
		next_cycle();
		@(negedge clk_sys);
		post_check("port_a_o", int'(joy_lines(joy, rnd[8])), int'(port_a_o), 0);
		next_cycle();
		joy_a_i = '0;
		@(negedge clk_sys);
		post_check("port_a_o", int'(joy_lines('0, stra_i)), int'(port_a_o), 0);
		finish_test();
	endtask

	task automatic joystick_test();
		logic [31:0] rnd;
		int          n;
		start_test("joystick ports");
		for (n = 0; n < 16; n++) begin
			next_cycle();
			rnd = $urandom;
			joy_a_i = rnd[5:0];
			joy_b_i = rnd[11:6];
			stra_i = rnd[12];
			strb_i = rnd[13];
			@(negedge clk_sys);
			post_check("port_a_o", int'(joy_lines(rnd[5:0], rnd[12])), int'(port_a_o), 0);
			post_check("port_b_o", int'(joy_lines(rnd[11:6], rnd[13])), int'(port_b_o), 0);
		end
		next_cycle();
		joy_a_i = '0;
		joy_b_i = '0;
		finish_test();
	endtask

	task automatic audio_test();
		audio_src_t  src;
		logic [31:0] rnd;
		volume_t     vol;
		logic        tape;
		int          set;
		int          ones_l;
		int          ones_r;
		start_test("audio mixing and volume");
		for (set = 0; set < AUDIO_SETS; set++) begin
			next_cycle();
			rnd = $urandom;
			src = random_sources();
			vol = (set == 0) ? 3'd7 : (set == 1) ? 3'd0 : rnd[2:0];
			tape = (set % 2 == 0);
			audio_src_i = src;
			volume_i = vol;
			ear_i = 1'b1;
			status_i = '0;
			status_i[TAPE_BIT] = tape;
			repeat (SETTLE) next_cycle();
			ones_l = 0;
			ones_r = 0;
			repeat (WINDOW) begin
				@(negedge clk_sys);
				ones_l = ones_l + int'(audio_l_o);
				ones_r = ones_r + int'(audio_r_o);
			end
			post_check("audio_l_o ones",
				mixed_dac_word(src, vol, tape, 1'b1, 1'b0) >> (16 - DAC_BITS), ones_l, 1);
			post_check("audio_r_o ones",
				mixed_dac_word(src, vol, tape, 1'b1, 1'b1) >> (16 - DAC_BITS), ones_r, 1);
		end
		finish_test();
	endtask

	initial begin
		#(5 * TOTAL_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("test failed");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		reset_i = 1'b1;
		pll_locked_i = 1'b1;
		button_reset_i = 1'b0;
		status_i = '0;
		img_mounted_i = 1'b0;
		mouse_strobe_i = 1'b0;
		mouse_i = '0;
		joy_a_i = '0;
		joy_b_i = '0;
		stra_i = 1'b0;
		strb_i = 1'b0;
		audio_src_i = '0;
		volume_i = 3'd7;
		ear_i = 1'b0;
		reset_dip_test();
		mouse_test();
		timeout_fallback_test();
		joystick_test();
		audio_test();
		$display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
			tests_run, tests_bad, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- list.f
design/msx_audio_pkg.sv
design/msx_io_pkg.sv
design/board_control.sv
design/mouse_port.sv
design/audio_mixer.sv
design/sigma_delta_dac.sv
design/msx_board_io.sv
tests/tb_msx_board_io.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then search the log for the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_msx_board_io -Mdir obj_dir -o tb_sim -f list.f \
	&& ./obj_dir/tb_sim > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"

grep -q "test failed" "$LOG" && exit 1 || exit 0
